// ==== build.f ====
rtl/board_pkg.sv
rtl/reset_pkg.sv
rtl/pb_debouncer.sv
rtl/reset_controller.sv
rtl/heartbeat_counter.sv
rtl/parallella_board_top.sv
sim/tb_clock_gen.sv
sim/tb_parallella_board.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compiles the board testbench with Verilator, runs it and checks the log

LOG=sim.log
BIN=tb_parallella_board

rm -f "$LOG"

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
   --top-module tb_parallella_board -f build.f -o "$BIN" > "$LOG" 2>&1 \
   && ./obj_dir/"$BIN" >> "$LOG" 2>&1 \
   || { cat "$LOG"; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q ">>> FAIL" "$LOG" && { echo "Simulation reported errors"; exit 1; }
grep -q ">>> PASS" "$LOG" || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation finished without errors"
exit 0

// ==== sim/board_stimulus.txt ====
// Columns: opcode, operand, expected value, all hex
// Ops: 00 end, 01 wait, 02 buttons, 03 sw resets, 04 led, 05 resetn, 06 pb_clean,
//      07 heartbeat after N edges, 08 bounce, 09 led moving, 0A wait resetn, 0B test

// Power-on reset, held for 40 cycles after release
0B 0001 0000
05 0000 0000
04 0000 00FF
01 0019 0000
05 0000 0000
04 0000 00FF
01 001E 0000
05 0000 0001
09 0008 0000

// Heartbeat exactness, LEDs are bits 9:2 of N inverted
0B 0002 0000
03 0001 0000
01 0004 0000
07 0025 00F6
03 0001 0000
01 0003 0000
07 0123 00B7
03 0001 0000
01 0003 0000
07 0406 00FE
03 0001 0000
01 0002 0000
07 0010 00FB
03 0001 0000
01 0002 0000
07 0003 00FF

// Debounce filtering on button 1
0B 0003 0000
08 0001 0000
01 0014 0000
06 0000 0000
08 0001 0000
01 0014 0000
06 0000 0000
02 0002 0000
01 0028 0000
06 0000 0002
02 0000 0000
01 0028 0000
06 0000 0000

// Reset button on button 0
0B 0004 0000
02 0001 0000
01 0028 0000
05 0000 0000
04 0000 00FF
06 0000 0001
02 0000 0000
01 0028 0000
0A 0040 0001
06 0000 0000
09 0008 0000

// Software chip reset leaves the heartbeat running
0B 0005 0000
03 0002 0000
01 0002 0000
05 0000 0000
09 0008 0000
03 0000 0000
01 0001 0000
05 0000 0001
00 0000 0000

// ==== sim/tb_parallella_board.sv ====
// Testbench for the board top, stepping through operations read from a stimulus file
`timescale 1ns/10ps
`default_nettype none

module tb_parallella_board;

   import board_pkg::*;

   // ################################################
   // Constants
   // ################################################

   localparam int DEBOUNCE_CYCLES = 16;         // Short filter for simulation
   localparam int POR_CYCLES      = 40;
   localparam int LED_LSB         = 2;          // LEDs show count bits 9:2
   localparam int STIM_WORDS      = 192;        // Three words per operation
   localparam int WATCHDOG_CYCLES = 20000;
   localparam int RELEASE_TIMEOUT = 20;

   // Operation codes in the first column of the stimulus file
   localparam logic [15:0] OP_END       = 16'h00;
   localparam logic [15:0] OP_WAIT      = 16'h01;
   localparam logic [15:0] OP_SET_PB    = 16'h02;
   localparam logic [15:0] OP_SET_SW    = 16'h03;    // Bit 0 fpga, bit 1 chip
   localparam logic [15:0] OP_CHK_LED   = 16'h04;
   localparam logic [15:0] OP_CHK_RSTN  = 16'h05;
   localparam logic [15:0] OP_CHK_PB    = 16'h06;
   localparam logic [15:0] OP_HEARTBEAT = 16'h07;
   localparam logic [15:0] OP_BOUNCE    = 16'h08;
   localparam logic [15:0] OP_LED_MOVE  = 16'h09;
   localparam logic [15:0] OP_WAIT_RSTN = 16'h0A;
   localparam logic [15:0] OP_TEST      = 16'h0B;

   // ################################################
   // Signals
   // ################################################

   logic        sys_clk;
   logic        fpga_reset;
   pb_vec_t     user_pb;
   logic        sw_fpga_reset;
   logic        sw_chip_reset;
   led_vec_t    user_led;
   pb_vec_t     user_pb_clean;
   logic        aafm_resetn;

   logic [15:0] stim_mem [0:STIM_WORDS-1];      // Opcode, operand, expected
   int          value_errors;
   int          other_errors;
   int          checks_done;
   integer      seed;                           // Bounce generator state
   string       test_name;

   tb_clock_gen #(
      .PERIOD_NS    (4),
      .RESET_CYCLES (3)
   ) u_clock_gen (
      .sys_clk    (sys_clk),
      .fpga_reset (fpga_reset)
   );

   parallella_board_top #(
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
      .POR_CYCLES      (POR_CYCLES),
      .LED_LSB         (LED_LSB)
   ) uut (
      .sys_clk       (sys_clk),
      .fpga_reset    (fpga_reset),
      .user_pb       (user_pb),
      .sw_fpga_reset (sw_fpga_reset),
      .sw_chip_reset (sw_chip_reset),
      .user_led      (user_led),
      .user_pb_clean (user_pb_clean),
      .aafm_resetn   (aafm_resetn)
   );

   // ################################################
   // Helpers
   // ################################################

   function automatic string name_of_test(input logic [15:0] id);
      case (id)
         16'd1:   return "power_on_reset";
         16'd2:   return "heartbeat";
         16'd3:   return "debounce";
         16'd4:   return "button_reset";
         16'd5:   return "chip_reset";
         default: return "unnamed";
      endcase
   endfunction

   task check_value(input string name, input logic [15:0] expected, input logic [15:0] actual);
      checks_done++;
      if (actual !== expected)
      begin
         value_errors++;
         $display("[FAIL] %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
      end
   endtask

   task report_error(input string what);
      other_errors++;
      $display("ERROR: %s at %0t", what, $time);
   endtask

   task wait_cycles(input int n);
      for (int i = 0; i < n; i++)
         @(posedge sys_clk);
   endtask

   // Outputs are read at the falling edge, then back onto a rising edge
   task check_output(input logic [15:0] op, input logic [15:0] expected);
      @(negedge sys_clk);
      case (op)
         OP_CHK_LED:  check_value({test_name, " user_led"}, expected, 16'(user_led));
         OP_CHK_RSTN: check_value({test_name, " aafm_resetn"}, expected, 16'(aafm_resetn));
         default:     check_value({test_name, " user_pb_clean"}, expected, 16'(user_pb_clean));
      endcase
      @(posedge sys_clk);
   endtask

   // Count is n after n edges past release, LEDs show its bits inverted
   task run_heartbeat(input logic [15:0] n, input logic [15:0] expected);
      sw_fpga_reset <= 1'b0;                    // Release on this edge
      wait_cycles(int'(n));
      @(negedge sys_clk);
      check_value({test_name, " user_led"}, expected, 16'(user_led));
      @(posedge sys_clk);
   endtask

   // Burst of 8 to 15 random levels, too short to pass the filter
   task bounce_button(input int idx);
      int          len;
      logic [31:0] rnd;
      logic        seen;                        // Any high seen on the clean output
      rnd  = $random(seed);
      len  = 8 + int'(rnd[2:0]);
      seen = 1'b0;
      // Watch the clean output through the burst and one filter length after it
      for (int i = 0; i < len + DEBOUNCE_CYCLES; i++)
      begin
         rnd = $random(seed);
         if (i < len)
            user_pb[idx] <= rnd[0];
         else
            user_pb[idx] <= 1'b0;               // Contact settles released
         @(negedge sys_clk);
         seen = seen | user_pb_clean[idx];
         @(posedge sys_clk);
      end
      check_value({test_name, " user_pb_clean during bounce"}, 16'h0000, 16'(seen));
   endtask

   task check_led_moving(input int n);
      led_vec_t first;
      @(negedge sys_clk);
      first = user_led;
      wait_cycles(n);
      @(negedge sys_clk);
      checks_done++;
      if (user_led === first)
         report_error({test_name, ": user_led stayed frozen, heartbeat not running"});
      @(posedge sys_clk);
   endtask

   task wait_for_resetn(input logic expected, input int timeout);
      int waited;
      waited = 0;
      @(negedge sys_clk);
      while (aafm_resetn !== expected && waited < timeout)
      begin
         @(negedge sys_clk);
         waited++;
      end
      if (aafm_resetn !== expected)
         report_error({test_name, ": timed out waiting for aafm_resetn to change"});
      @(posedge sys_clk);
   endtask

   // ################################################
   // Stimulus sequencer
   // ################################################

   initial
   begin
      logic [15:0] op;
      logic [15:0] operand;
      logic [15:0] expected;
      int          pc;
      int          waited;
      bit          running;

      user_pb       <= '0;
      sw_fpga_reset <= 1'b0;
      sw_chip_reset <= 1'b0;
      seed          = 32'h8a60_8558;
      value_errors  = 0;
      other_errors  = 0;
      checks_done   = 0;
      test_name     = "setup";
      $readmemh("sim/board_stimulus.txt", stim_mem);

      waited = 0;
      while (fpga_reset !== 1'b0 && waited < RELEASE_TIMEOUT)
      begin
         @(posedge sys_clk);
         waited++;
      end
      if (fpga_reset !== 1'b0)
         report_error("board reset was never released by the clock source");

      pc      = 0;
      running = 1'b1;
      while (running && pc + 2 < STIM_WORDS)
      begin
         op       = stim_mem[pc];
         operand  = stim_mem[pc + 1];
         expected = stim_mem[pc + 2];
         pc       = pc + 3;
         case (op)
            OP_END:       running = 1'b0;
            OP_WAIT:      wait_cycles(int'(operand));
            OP_SET_PB:    user_pb <= operand[NUM_PB-1:0];
            OP_SET_SW:
            begin
               sw_fpga_reset <= operand[0];
               sw_chip_reset <= operand[1];
            end
            OP_CHK_LED,
            OP_CHK_RSTN,
            OP_CHK_PB:    check_output(op, expected);
            OP_HEARTBEAT: run_heartbeat(operand, expected);
            OP_BOUNCE:    bounce_button(int'(operand));
            OP_LED_MOVE:  check_led_moving(int'(operand));
            OP_WAIT_RSTN: wait_for_resetn(expected[0], int'(operand));
            OP_TEST:
            begin
               test_name = name_of_test(operand);
               $display("Running test %s", test_name);
            end
            default:
            begin
               report_error("unknown operation in stimulus file, stopping");
               running = 1'b0;
            end
         endcase
      end

      $display("Summary: %0d checks, %0d value errors, %0d other errors",
               checks_done, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   // Stops a run whose stimulus never reaches its end
   initial
   begin
      for (int c = 0; c < WATCHDOG_CYCLES; c++)
         @(posedge sys_clk);
      $display("ERROR: watchdog expired after %0d cycles, stimulus unfinished", WATCHDOG_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

endmodule : tb_parallella_board

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
// Testbench clock source with a fixed period and a power-up reset pulse
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen
#(
   parameter int PERIOD_NS    = 4,              // Clock period
   parameter int RESET_CYCLES = 3               // Rising edges with reset held
)
(
   output logic sys_clk,
   output logic fpga_reset
);

   // ################################################
   // Clock and reset
   // ################################################

   initial
   begin
      sys_clk = 1'b0;
      forever
         #(PERIOD_NS / 2) sys_clk = ~sys_clk;   // 2 ns half period
   end

   // Reset drops on an edge, same as the other DUT inputs
   initial
   begin
      fpga_reset <= 1'b1;                       // Held from time zero
      for (int i = 0; i < RESET_CYCLES; i++)
         @(posedge sys_clk);
      fpga_reset <= 1'b0;
   end

endmodule : tb_clock_gen

`default_nettype wire

// ==== rtl/parallella_board_top.sv ====
// Board top joining the button debouncers, reset controller and heartbeat LEDs
`timescale 1ns/10ps
`default_nettype none

module parallella_board_top
#(
   parameter int DEBOUNCE_CYCLES = 1048576,     // 2^20 stable cycles
   parameter int POR_CYCLES      = 1045311,     // Power-on hold length
   parameter int LED_LSB         = 23           // Heartbeat tap position
)
(
   input  logic                sys_clk,
   input  logic                fpga_reset,      // Board reset, active high
   input  board_pkg::pb_vec_t  user_pb,         // Raw pushbuttons
   input  logic                sw_fpga_reset,   // Software logic reset
   input  logic                sw_chip_reset,   // Software board reset
   output board_pkg::led_vec_t user_led,        // Heartbeat LEDs
   output board_pkg::pb_vec_t  user_pb_clean,   // Debounced pushbuttons
   output logic                aafm_resetn      // Accelerator board reset
);

   import board_pkg::*;
   import reset_pkg::*;

   reset_req_t reset_req;                       // Triggers into reset controller
   logic       logic_reset;                     // Combined FPGA logic reset

   // ################################################
   // Pushbutton debouncers
   // ################################################

   for (genvar k = 0; k < NUM_PB; k++)
   begin : gen_debounce
      pb_debouncer #(
         .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
      ) u_debouncer (
         .sys_clk    (sys_clk),
         .fpga_reset (fpga_reset),
         .noisy_in   (user_pb[k]),
         .clean_out  (user_pb_clean[k])
      );
   end

   // ################################################
   // Reset tree
   // ################################################

   // Power-on term is filled in by the reset controller itself
   assign reset_req = '{
      por:     1'b0,
      pb:      user_pb_clean[0],                // SW5 is the reset button
      sw_fpga: sw_fpga_reset,
      sw_chip: sw_chip_reset
   };

   reset_controller #(
      .POR_CYCLES (POR_CYCLES)
   ) u_reset_controller (
      .sys_clk     (sys_clk),
      .fpga_reset  (fpga_reset),
      .reset_req   (reset_req),
      .logic_reset (logic_reset),
      .aafm_resetn (aafm_resetn)
   );

   // ################################################
   // Heartbeat
   // ################################################

   heartbeat_counter #(
      .LED_LSB (LED_LSB)
   ) u_heartbeat_counter (
      .sys_clk     (sys_clk),
      .logic_reset (logic_reset),               // Counter frozen in any reset
      .user_led    (user_led)
   );

endmodule : parallella_board_top

`default_nettype wire

// ==== rtl/heartbeat_counter.sv ====
// Heartbeat counter that blinks the user LEDs from a free-running alive count
`timescale 1ns/10ps
`default_nettype none

module heartbeat_counter
#(
   parameter int LED_LSB = 23                   // Lowest count bit on the LEDs
)
(
   input  logic                sys_clk,
   input  logic                logic_reset,     // Clears the count asynchronously
   output board_pkg::led_vec_t user_led         // Inverted count tap
);

   import board_pkg::*;

   alive_count_t alive_cnt;                     // Free-running count

   // ################################################
   // Alive counter
   // ################################################

   always_ff @(posedge sys_clk or posedge logic_reset)
   begin
      if (logic_reset)
         alive_cnt <= '0;                       // Held at zero in reset
      else
         alive_cnt <= alive_cnt + 1'b1;         // Wraps after 2^ALIVE_W
   end

   // ################################################
   // LED tap
   // ################################################

   // LEDs are active low, so a board in reset shows all ones
   assign user_led = ~alive_cnt[LED_LSB +: NUM_LED];

endmodule : heartbeat_counter

`default_nettype wire

// ==== rtl/reset_controller.sv ====
// Reset controller with the power-on counter FSM and the reset trigger combining
`timescale 1ns/10ps
`default_nettype none

module reset_controller
#(
   parameter int POR_CYCLES = 1045311           // Power-on hold length in cycles
)
(
   input  logic                  sys_clk,
   input  logic                  fpga_reset,    // Board reset, also restarts POR
   input  reset_pkg::reset_req_t reset_req,     // Button and software triggers
   output logic                  logic_reset,   // Active-high FPGA logic reset
   output logic                  aafm_resetn    // Active-low accelerator board reset
);

   import reset_pkg::*;

   localparam int POR_W = $clog2(POR_CYCLES + 1);

   typedef logic [POR_W-1:0] por_cnt_t;

   por_state_t por_state;                       // Power-on FSM state
   por_cnt_t   por_cnt;                         // Cycles since release
   logic       por_active;                      // Power-on term

   // ################################################
   // Power-on reset
   // ################################################

   always_ff @(posedge sys_clk or posedge fpga_reset)
   begin
      if (fpga_reset)
      begin
         por_state <= POR_COUNTING;             // Start over on every board reset
         por_cnt   <= '0;
      end
      else
      begin
         case (por_state)
            POR_COUNTING:
            begin
               if (por_cnt == por_cnt_t'(POR_CYCLES))
                  por_state <= POR_DONE;        // Hold time expired
               else
                  por_cnt <= por_cnt + 1'b1;    // Keep counting
            end
            POR_DONE:
            begin
               por_state <= POR_DONE;           // Sticky until fpga_reset
               por_cnt   <= por_cnt;
            end
         endcase
      end
   end

   // Asserted in reset and throughout the count
   assign por_active = (por_state == POR_COUNTING);

   // ################################################
   // Reset combining
   // ################################################

   // The por field of reset_req is not used here, the local
   // counter is the only source of the power-on term

   // FPGA logic reset, combinational so a software reset acts at once
   assign logic_reset = fpga_reset
                      | por_active              // Power-on hold
                      | reset_req.pb            // Reset button
                      | reset_req.sw_fpga;      // Software FPGA reset

   // Accelerator board reset, low while any trigger is active
   assign aafm_resetn = ~(por_active
                        | reset_req.pb
                        | reset_req.sw_chip);   // Software chip reset

endmodule : reset_controller

`default_nettype wire

// ==== rtl/pb_debouncer.sv ====
// Pushbutton debouncer with a two-flop synchronizer and a stability counter
`timescale 1ns/10ps
`default_nettype none

module pb_debouncer
#(
   parameter int DEBOUNCE_CYCLES = 1048576      // Stable cycles before output follows
)
(
   input  logic sys_clk,
   input  logic fpga_reset,
   input  logic noisy_in,                       // Raw button, asynchronous
   output logic clean_out                       // Filtered level
);

   localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

   typedef logic [CNT_W-1:0] stable_cnt_t;

   logic        sync_meta;                      // First sync stage
   logic        sync_q;                         // Second sync stage
   stable_cnt_t stable_cnt;                     // Cycles the new level has held

   // ################################################
   // Synchronizer
   // ################################################

   always_ff @(posedge sys_clk or posedge fpga_reset)
   begin
      if (fpga_reset)
      begin
         sync_meta <= 1'b0;
         sync_q    <= 1'b0;
      end
      else
      begin
         sync_meta <= noisy_in;                 // May go metastable
         sync_q    <= sync_meta;                // Settled copy
      end
   end

   // ################################################
   // Stability filter
   // ################################################

   // Counter only runs while the synced level differs from the output,
   // so any bounce back to the old level restarts the count from zero
   always_ff @(posedge sys_clk or posedge fpga_reset)
   begin
      if (fpga_reset)
      begin
         stable_cnt <= '0;
         clean_out  <= 1'b0;                    // Button released after reset
      end
      else if (sync_q == clean_out)
         stable_cnt <= '0;                      // No pending change
      else if (stable_cnt == stable_cnt_t'(DEBOUNCE_CYCLES - 1))
      begin
         stable_cnt <= '0;                      // Count hits limit this edge
         clean_out  <= sync_q;                  // Accept new level
      end
      else
         stable_cnt <= stable_cnt + 1'b1;       // Still bouncing or settling
   end

endmodule : pb_debouncer

`default_nettype wire

// ==== rtl/reset_pkg.sv ====
// Reset package with the reset trigger struct and the power-on FSM states
`default_nettype none

package reset_pkg;

   // ################################################
   // Reset triggers
   // ################################################

   // All triggers are plain active-high levels
   typedef struct packed {
      logic por;                                // Power-on reset still active
      logic pb;                                 // Debounced reset button
      logic sw_fpga;                            // Software reset of FPGA logic
      logic sw_chip;                            // Software reset of accelerator board
   } reset_req_t;

   // ################################################
   // Power-on FSM
   // ################################################

   typedef enum logic {
      POR_COUNTING,                             // Holding reset, counter running
      POR_DONE                                  // Count expired, reset released
   } por_state_t;

endpackage : reset_pkg

`default_nettype wire

// ==== rtl/board_pkg.sv ====
// Board package with the pushbutton, LED and alive counter widths and vector types
`default_nettype none

package board_pkg;

   // ################################################
   // Board widths
   // ################################################

   localparam int NUM_PB  = 2;                  // User pushbuttons SW5, SW7
   localparam int NUM_LED = 8;                  // User LED bank
   localparam int ALIVE_W = 32;                 // Heartbeat counter width

   // ################################################
   // Vector types
   // ################################################

   // One bit per button, bit 0 is the reset button
   typedef logic [NUM_PB-1:0]  pb_vec_t;

   // LED drive, active low on the board
   typedef logic [NUM_LED-1:0] led_vec_t;

   typedef logic [ALIVE_W-1:0] alive_count_t;   // Free-running alive count

endpackage : board_pkg

`default_nettype wire
